// ==== controlUnit_testdata.hex ====
// ir ctl expected bus, one record per clock. ctl bit 1 is stop and bit 0 is conFlag.
// expected holds the outputs from run down to memEnable in port order, bus is busSelect.
18918000 0 4000000 0 // first edge after reset
18918000 0 5100200 0 // add r1, r2, r3
18918000 0 4C00005 5
18918000 0 4200000 4
18918000 0 4080090 6
18918000 0 4100C50 0
18918000 0 4000120 0
8A280000 0 5100200 4 // neg r4, r5
8A280000 0 4C00005 5
8A280000 0 4200000 4
8A280000 0 4104490 6
8A280000 0 4000020 0
A3000000 0 5100200 4 // jump r6
A3000000 0 4C00005 5
A3000000 0 4200000 4
A3000000 0 4400110 6
79180000 0 5100200 0 // mul r2, r3
79180000 0 4C00005 5
79180000 0 4200000 4
79180000 0 4080090 6
79180000 0 4103D00 0
79180000 0 4040000 0
79180000 0 4020000 3
00800020 0 5100200 4 // load r1, 0x20 with rb zero
00800020 0 4C00005 5
00800020 0 4200000 4
00800020 0 4080098 6
00800020 0 4100C00 0
00800020 0 5000000 8
00800020 0 4800005 4
00800020 0 4000120 0
01180010 0 5100200 6 // load r2, 0x10(r3) with stop held in T4
01180010 0 4C00005 5
01180010 0 4200000 4
01180010 0 4080090 6
01180010 2 0100C00 0
01180010 2 0100C00 8
01180010 2 0100C00 8
01180010 2 0100C00 8
01180010 0 4100C00 8
01180010 0 5000000 8
01180010 0 4800005 4
01180010 0 4000120 0
11A00008 0 5100200 6 // store r3, 8(r4)
11A00008 0 4C00005 5
11A00008 0 4200000 4
11A00008 0 4080090 6
11A00008 0 4100C00 0
11A00008 0 5000000 8
11A00008 0 4800110 4
11A00008 0 4000003 0
9A88000C 0 5100200 6 // branch, conFlag low
9A88000C 0 4C00005 5
9A88000C 0 4200000 4
9A88000C 0 4010100 6
9A88000C 0 4080000 0
9A88000C 0 4100C00 5
9A88000C 0 4000000 8
9A880010 1 5100200 4 // branch, conFlag high
9A880010 1 4C00005 5
9A880010 1 4200000 4
9A880010 1 4010100 6
9A880010 1 4080000 0
9A880010 1 4100C00 5
9A880010 1 4400000 8
D0000000 0 5100200 4 // nop
D0000000 0 4C00005 5
D0000000 0 4200000 4
D0000000 0 4000000 6
D8000000 0 5100200 0 // halt, then held in T3
D8000000 0 4C00005 5
D8000000 0 4200000 4
D8000000 0 0000000 6
D8000000 0 0000000 0
D8000000 0 0000000 0
D8000000 0 0000000 0

// ==== compile.f ====
+incdir+.
isaPkg.sv
controlPkg.sv
opDecode.sv
stepSequencer.sv
controlEncoder.sv
busSelectEncoder.sv
controlUnit.sv
controlUnit_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the control unit testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f compile.f --top-module controlUnit_tb
./obj_dir/VcontrolUnit_tb

// ==== controlUnit_tb.sv ====
module controlUnit_tb;
    import isaPkg::*;
    import controlPkg::*;

    localparam int recordCount    = 76;
    localparam int wordsPerRecord = 4;
    // Eight reset cycles plus one per record, with room to spare.
    localparam int cycleLimit     = recordCount + 20;

    logic        clk;
    logic        reset;
    logic        stop;
    logic        conFlag;
    instrWord_u  ir;
    logic        run;
    logic        clear;
    busSource_e  busSelect;
    logic        marIn;
    logic        mdrIn;
    logic        pcIn;
    logic        irIn;
    logic        zIn;
    logic        yIn;
    logic        hiIn;
    logic        loIn;
    logic        conIn;
    logic        outportIn;
    aluOp_e      aluOp;
    logic        incPc;
    logic        gra;
    logic        grb;
    logic        grc;
    logic        rIn;
    logic        rOut;
    logic        baOut;
    logic        memRead;
    logic        memWrite;
    logic        memEnable;

    // Four words per record: ir, stop and conFlag, expected outputs, expected busSelect.
    logic [31:0] testData [0:recordCount*wordsPerRecord-1];
    int          cycleCount;

    controlUnit u_controlUnit (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected 0x%0h, got 0x%0h at time %0t",
                     name, expected, actual, $time);
            $display("** FAIL **");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic driveInputs(input int index);
        ir      = testData[index*wordsPerRecord];
        stop    = testData[index*wordsPerRecord+1][1];
        conFlag = testData[index*wordsPerRecord+1][0];
    endtask

    // Vector bits from 26 down: run, clear, the ten enables, aluOp, incPc,
    // the register selects and the memory controls.
    task automatic compareOutputs(input logic [26:0] expVec, input logic [3:0] expBus);
        checkValue("run",       32'(run),       32'(expVec[26]));
        checkValue("clear",     32'(clear),     32'(expVec[25]));
        checkValue("marIn",     32'(marIn),     32'(expVec[24]));
        checkValue("mdrIn",     32'(mdrIn),     32'(expVec[23]));
        checkValue("pcIn",      32'(pcIn),      32'(expVec[22]));
        checkValue("irIn",      32'(irIn),      32'(expVec[21]));
        checkValue("zIn",       32'(zIn),       32'(expVec[20]));
        checkValue("yIn",       32'(yIn),       32'(expVec[19]));
        checkValue("hiIn",      32'(hiIn),      32'(expVec[18]));
        checkValue("loIn",      32'(loIn),      32'(expVec[17]));
        checkValue("conIn",     32'(conIn),     32'(expVec[16]));
        checkValue("outportIn", 32'(outportIn), 32'(expVec[15]));
        checkValue("aluOp",     32'(aluOp),     32'(expVec[14:10]));
        checkValue("incPc",     32'(incPc),     32'(expVec[9]));
        checkValue("gra",       32'(gra),       32'(expVec[8]));
        checkValue("grb",       32'(grb),       32'(expVec[7]));
        checkValue("grc",       32'(grc),       32'(expVec[6]));
        checkValue("rIn",       32'(rIn),       32'(expVec[5]));
        checkValue("rOut",      32'(rOut),      32'(expVec[4]));
        checkValue("baOut",     32'(baOut),     32'(expVec[3]));
        checkValue("memRead",   32'(memRead),   32'(expVec[2]));
        checkValue("memWrite",  32'(memWrite),  32'(expVec[1]));
        checkValue("memEnable", 32'(memEnable), 32'(expVec[0]));
        checkValue("busSelect", 32'(busSelect), 32'(expBus));
    endtask

    initial begin
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("** FAIL **");
        $fatal(1, "run did not finish");
    end

    initial begin
        reset   = 1'b1;
        stop    = 1'b0;
        conFlag = 1'b0;
        ir      = '0;
        $readmemh("controlUnit_testdata.hex", testData);
        repeat (8) @(negedge clk);
        // Only clear is high while reset holds.
        compareOutputs(27'h2000000, 4'h0);
        reset = 1'b0;
        // Outputs of each record are sampled one falling edge after its inputs.
        for (int r = 0; r < recordCount; r++) begin
            driveInputs(r);
            @(negedge clk);
            compareOutputs(testData[r*wordsPerRecord+2][26:0],
                           testData[r*wordsPerRecord+3][3:0]);
        end
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== controlUnit.sv ====
module controlUnit (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stop,
    input  isaPkg::instrWord_u     ir,
    input  logic                   conFlag,
    output logic                   run,
    output logic                   clear,
    output controlPkg::busSource_e busSelect,
    output logic                   marIn,
    output logic                   mdrIn,
    output logic                   pcIn,
    output logic                   irIn,
    output logic                   zIn,
    output logic                   yIn,
    output logic                   hiIn,
    output logic                   loIn,
    output logic                   conIn,
    output logic                   outportIn,
    output controlPkg::aluOp_e     aluOp,
    output logic                   incPc,
    output logic                   gra,
    output logic                   grb,
    output logic                   grc,
    output logic                   rIn,
    output logic                   rOut,
    output logic                   baOut,
    output logic                   memRead,
    output logic                   memWrite,
    output logic                   memEnable
);
    import isaPkg::*;
    import controlPkg::*;

    instrClass_e instrClass;
    logic        directAddr;
    step_e       step;
    logic [8:0]  busDrive;

    opDecode u_opDecode (
        .clk        (clk),
        .reset      (reset),
        .ir         (ir),
        .step       (step),
        .instrClass (instrClass),
        .directAddr (directAddr)
    );

    stepSequencer u_stepSequencer (
        .clk        (clk),
        .reset      (reset),
        .stop       (stop),
        .instrClass (instrClass),
        .step       (step),
        .run        (run),
        .clear      (clear)
    );

    controlEncoder u_controlEncoder (
        .clk        (clk),
        .reset      (reset),
        .step       (step),
        .instrClass (instrClass),
        .directAddr (directAddr),
        .conFlag    (conFlag),
        .marIn      (marIn),
        .mdrIn      (mdrIn),
        .pcIn       (pcIn),
        .irIn       (irIn),
        .zIn        (zIn),
        .yIn        (yIn),
        .hiIn       (hiIn),
        .loIn       (loIn),
        .conIn      (conIn),
        .outportIn  (outportIn),
        .aluOp      (aluOp),
        .incPc      (incPc),
        .gra        (gra),
        .grb        (grb),
        .grc        (grc),
        .rIn        (rIn),
        .rOut       (rOut),
        .baOut      (baOut),
        .memRead    (memRead),
        .memWrite   (memWrite),
        .memEnable  (memEnable),
        .busDrive   (busDrive)
    );

    busSelectEncoder u_busSelectEncoder (
        .clk        (clk),
        .reset      (reset),
        .busDrive   (busDrive),
        .busSelect  (busSelect)
    );

endmodule

// ==== busSelectEncoder.sv ====
module busSelectEncoder (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [8:0]             busDrive,
    output controlPkg::busSource_e busSelect
);
    import controlPkg::*;

    busSource_e selNext;

    // Bit positions match the bus codes. Bit 0 and an empty vector mean none.
    always_comb begin
        selNext = busNone;
        for (int i = 1; i < 9; i++) begin
            if (busDrive[i]) begin
                selNext = busSource_e'(4'(i));
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busSelect <= busNone;
        end else begin
            busSelect <= selNext;
        end
    end

    // Two drivers on the shared bus would collide in the datapath.
    busDriveOneHot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(busDrive));

endmodule

// ==== controlEncoder.sv ====
`include "cpuControl_macros.svh"

module controlEncoder (
    input  logic                clk,
    input  logic                reset,
    input  controlPkg::step_e   step,
    input  isaPkg::instrClass_e instrClass,
    input  logic                directAddr,
    input  logic                conFlag,
    output logic                marIn,
    output logic                mdrIn,
    output logic                pcIn,
    output logic                irIn,
    output logic                zIn,
    output logic                yIn,
    output logic                hiIn,
    output logic                loIn,
    output logic                conIn,
    output logic                outportIn,
    output controlPkg::aluOp_e  aluOp,
    output logic                incPc,
    output logic                gra,
    output logic                grb,
    output logic                grc,
    output logic                rIn,
    output logic                rOut,
    output logic                baOut,
    output logic                memRead,
    output logic                memWrite,
    output logic                memEnable,
    output logic [8:0]          busDrive
);
    import isaPkg::*;
    import controlPkg::*;

    logic [`CTRL_STEP_COUNT-1:0] t;
    logic isLoad, isLoadi, isStore, isAlu, isImm, isArith;
    logic isMulDiv, isNegNot, isBranch, isJump, isJal;
    logic isIn, isOut, isMfhi, isMflo;
    logic [8:0] driveNext;
    aluOp_e     aluNext;

    assign t = `CTRL_STEP_COUNT'(1) << step;

    assign isLoad   = instrClass == clsLoad;
    assign isLoadi  = instrClass == clsLoadi;
    assign isStore  = instrClass == clsStore;
    assign isAlu    = instrClass inside {clsAdd, clsSub, clsShr, clsShra, clsShl,
                                         clsRor, clsRol, clsAnd, clsOr};
    assign isImm    = instrClass inside {clsAddi, clsAndi, clsOri};
    assign isArith  = isLoad | isLoadi | isStore | isAlu | isImm;
    assign isMulDiv = instrClass inside {clsMul, clsDiv};
    assign isNegNot = instrClass inside {clsNeg, clsNot};
    assign isBranch = instrClass == clsBranch;
    assign isJump   = instrClass == clsJump;
    assign isJal    = instrClass == clsJumpLink;
    assign isIn     = instrClass == clsIn;
    assign isOut    = instrClass == clsOut;
    assign isMfhi   = instrClass == clsMfhi;
    assign isMflo   = instrClass == clsMflo;

    // One bus driver per step, none when nothing else drives.
    always_comb begin
        driveNext            = '0;
        driveNext[busHi]     = t[3] & isMfhi;
        driveNext[busLo]     = t[3] & isMflo;
        driveNext[busZhi]    = t[5] & isMulDiv;
        driveNext[busZlo]    = t[1] | (t[4] & isNegNot) | (t[5] & isArith) |
                               (t[6] & (isMulDiv | isBranch));
        driveNext[busPc]     = t[0] | (t[4] & isBranch) | (t[3] & isJal);
        driveNext[busMdr]    = t[2] | (t[7] & (isLoad | isStore));
        driveNext[busInport] = t[3] & isIn;
        driveNext[busC]      = t[4] & (isLoad | isLoadi | isStore | isImm) |
                               (t[5] & isBranch);
        driveNext[busNone]   = ~|driveNext[8:1];
    end

    always_comb begin
        aluNext = aluNone;
        if (t[4]) begin
            case (instrClass)
                clsLoad, clsLoadi, clsStore, clsAdd, clsAddi: aluNext = aluAdd;
                clsSub:          aluNext = aluSub;
                clsShr:          aluNext = aluShr;
                clsShra:         aluNext = aluShra;
                clsShl:          aluNext = aluShl;
                clsRor:          aluNext = aluRor;
                clsRol:          aluNext = aluRol;
                clsAnd, clsAndi: aluNext = aluAnd;
                clsOr, clsOri:   aluNext = aluOr;
                clsMul:          aluNext = aluMul;
                clsDiv:          aluNext = aluDiv;
                default:         aluNext = aluNone;
            endcase
        end else if (t[3] && instrClass == clsNeg) begin
            aluNext = aluNeg;
        end else if (t[3] && instrClass == clsNot) begin
            aluNext = aluNot;
        end else if (t[5] && isBranch) begin
            // Branch target is pc plus the constant.
            aluNext = aluAdd;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            {marIn, mdrIn, pcIn, irIn, zIn, yIn, hiIn, loIn, conIn, outportIn} <= '0;
            {incPc, gra, grb, grc, rIn, rOut, baOut} <= '0;
            {memRead, memWrite, memEnable} <= '0;
            aluOp    <= aluNone;
            busDrive <= '0;
        end else begin
            marIn     <= t[0] | (t[5] & (isLoad | isStore));
            mdrIn     <= t[1] | (t[6] & (isLoad | isStore));
            pcIn      <= t[1] | (t[3] & isJump) | (t[4] & isJal) |
                         (t[6] & isBranch & conFlag);
            irIn      <= t[2];
            zIn       <= t[0] | (t[4] & (isArith | isMulDiv)) | (t[3] & isNegNot) |
                         (t[5] & isBranch);
            yIn       <= (t[3] & (isArith | isMulDiv)) | (t[4] & isBranch);
            hiIn      <= t[5] & isMulDiv;
            loIn      <= t[6] & isMulDiv;
            conIn     <= t[3] & isBranch;
            outportIn <= t[3] & isOut;
            aluOp     <= aluNext;
            incPc     <= t[0];
            gra       <= (t[3] & (isBranch | isJump | isMfhi | isMflo)) |
                         (t[4] & (isMulDiv | isJal)) |
                         (t[5] & (isLoadi | isAlu | isImm)) |
                         (t[6] & isStore) | (t[7] & isLoad);
            grb       <= t[3] & (isArith | isMulDiv | isNegNot | isJal);
            grc       <= t[4] & isAlu;
            rIn       <= (t[3] & (isJal | isMfhi | isMflo | isIn)) | (t[4] & isNegNot) |
                         (t[5] & (isLoadi | isAlu | isImm)) | (t[7] & isLoad);
            rOut      <= (t[3] & (isArith | isMulDiv | isNegNot | isJump | isOut)) |
                         (t[4] & (isAlu | isJal)) | (t[6] & isStore);
            baOut     <= (t[3] & directAddr) | (t[6] & isStore & directAddr);
            memRead   <= t[1] | (t[6] & isLoad);
            memWrite  <= t[7] & isStore;
            memEnable <= t[1] | (t[6] & isLoad) | (t[7] & isStore);
            busDrive  <= driveNext;
        end
    end

endmodule

// ==== stepSequencer.sv ====
module stepSequencer (
    input  logic                clk,
    input  logic                reset,
    input  logic                stop,
    input  isaPkg::instrClass_e instrClass,
    output controlPkg::step_e   step,
    output logic                run,
    output logic                clear
);
    import isaPkg::*;
    import controlPkg::*;

    step_e lastStep;
    logic  halted;

    // Final execute step of each class.
    always_comb begin
        case (instrClass)
            clsNeg, clsNot, clsJumpLink: begin
                lastStep = stepT4;
            end
            clsLoadi, clsAdd, clsSub, clsShr, clsShra, clsShl, clsRor, clsRol,
            clsAnd, clsOr, clsAddi, clsAndi, clsOri: begin
                lastStep = stepT5;
            end
            clsMul, clsDiv, clsBranch: begin
                lastStep = stepT6;
            end
            clsLoad, clsStore: begin
                lastStep = stepT7;
            end
            default: begin
                lastStep = stepT3;
            end
        endcase
    end

    assign halted = (instrClass == clsHalt) && (step == stepT3);

    // Reset parks the step at T7 so the first edge enters T0.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            step  <= stepT7;
            clear <= 1'b1;
            run   <= 1'b0;
        end else begin
            run <= !stop && !halted;
            if (!stop) begin
                clear <= 1'b0;
                if (clear || (step == lastStep)) begin
                    if (!halted) begin
                        step <= stepT0;
                    end
                end else begin
                    step <= step_e'(step + 3'd1);
                end
            end
        end
    end

    // Class comes from the decoder, so this ties both stages together.
    stepInRange: assert property (@(posedge clk) disable iff (reset || clear)
        step <= lastStep);

endmodule

// ==== opDecode.sv ====
module opDecode (
    input  logic                clk,
    input  logic                reset,
    input  isaPkg::instrWord_u  ir,
    input  controlPkg::step_e   step,
    output isaPkg::instrClass_e instrClass,
    output logic                directAddr
);
    import isaPkg::*;
    import controlPkg::*;

    opcode_e     opcode;
    instrClass_e classNext;
    logic        directNext;

    assign opcode = opcode_e'(ir.branchForm.op);

    // Codes above halt are not in the instruction set.
    always_comb begin
        if (opcode > opHalt) begin
            classNext = clsIllegal;
        end else begin
            classNext = instrClass_e'(opcode);
        end
    end

    // rb of zero selects direct addressing for memory forms.
    assign directNext = (opcode inside {opLoad, opLoadi, opStore}) &&
                        (ir.regForm.rb == 4'd0);

    // Latched as fetch completes, ir is stable from T3 onwards.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            instrClass <= clsIllegal;
            directAddr <= 1'b0;
        end else if (step == stepT2) begin
            instrClass <= classNext;
            directAddr <= directNext;
        end
    end

endmodule

// ==== controlPkg.sv ====
`include "cpuControl_macros.svh"

package controlPkg;

    typedef enum logic [$clog2(`CTRL_STEP_COUNT)-1:0] {
        stepT0, stepT1, stepT2, stepT3,
        stepT4, stepT5, stepT6, stepT7
    } step_e;

    // Bus driver codes as seen by the datapath bus multiplexer.
    typedef enum logic [3:0] {
        busNone   = 4'd0,
        busHi     = 4'd1,
        busLo     = 4'd2,
        busZhi    = 4'd3,
        busZlo    = 4'd4,
        busPc     = 4'd5,
        busMdr    = 4'd6,
        busInport = 4'd7,
        busC      = 4'd8
    } busSource_e;

    typedef enum logic [4:0] {
        aluNone = 5'b00000,
        aluAdd  = 5'b00011,
        aluSub  = 5'b00100,
        aluShr  = 5'b00101,
        aluShra = 5'b00110,
        aluShl  = 5'b00111,
        aluRor  = 5'b01000,
        aluRol  = 5'b01001,
        aluOr   = 5'b01010,
        aluAnd  = 5'b01011,
        aluMul  = 5'b01111,
        aluDiv  = 5'b10000,
        aluNeg  = 5'b10001,
        aluNot  = 5'b10010
    } aluOp_e;

endpackage

// ==== isaPkg.sv ====
`include "cpuControl_macros.svh"

package isaPkg;

    // Register form and branch form share the opcode and ra fields.
    typedef union packed {
        struct packed {
            logic [`CTRL_OPCODE_WIDTH-1:0]                     op;
            logic [3:0]                                        ra;
            logic [3:0]                                        rb;
            logic [3:0]                                        rc;
            logic [`CTRL_DATA_WIDTH-`CTRL_OPCODE_WIDTH-13:0]   unused;
        } regForm;
        struct packed {
            logic [`CTRL_OPCODE_WIDTH-1:0]                     op;
            logic [3:0]                                        ra;
            logic [3:0]                                        cond;
            logic [`CTRL_DATA_WIDTH-`CTRL_OPCODE_WIDTH-9:0]    constant;
        } branchForm;
    } instrWord_u;

    typedef enum logic [`CTRL_OPCODE_WIDTH-1:0] {
        opLoad = 5'd0, opLoadi, opStore,
        opAdd, opSub, opShr, opShra, opShl, opRor, opRol, opAnd, opOr,
        opAddi, opAndi, opOri,
        opMul, opDiv, opNeg, opNot,
        opBranch, opJump, opJumpLink,
        opIn, opOut, opMfhi, opMflo,
        opNop, opHalt
    } opcode_e;

    // Class codes follow the opcode codes, with illegal appended.
    typedef enum logic [`CTRL_OPCODE_WIDTH-1:0] {
        clsLoad = 5'd0, clsLoadi, clsStore,
        clsAdd, clsSub, clsShr, clsShra, clsShl, clsRor, clsRol, clsAnd, clsOr,
        clsAddi, clsAndi, clsOri,
        clsMul, clsDiv, clsNeg, clsNot,
        clsBranch, clsJump, clsJumpLink,
        clsIn, clsOut, clsMfhi, clsMflo,
        clsNop, clsHalt,
        clsIllegal
    } instrClass_e;

endpackage

// ==== cpuControl_macros.svh ====
`ifndef CPU_CONTROL_MACROS_SVH
`define CPU_CONTROL_MACROS_SVH

// Instruction word and opcode field widths.
`define CTRL_DATA_WIDTH   32
`define CTRL_OPCODE_WIDTH 5

// Control steps T0 to T7.
`define CTRL_STEP_COUNT   8

`endif
